// ==== Bender.yml ====
package:
  name: sdram_nes

export_include_dirs:
  - .

sources:
  - sdram_nes_pkg.sv
  - sdram_sequencer.sv
  - nes_channel.sv
  - rv_channel.sv
  - sdram_bus_driver.sv
  - sdram_nes.sv
  - target: test
    files:
      - sdram_model.sv
      - sdram_nes_sva.sv
      - tb_sdram_nes.sv

// ==== flist.f ====
+incdir+.
sdram_nes_pkg.sv
sdram_sequencer.sv
nes_channel.sv
rv_channel.sv
sdram_bus_driver.sv
sdram_nes.sv
sdram_model.sv
sdram_nes_sva.sv
tb_sdram_nes.sv

// ==== nes_channel.sv ====
/*
 * channel 0: CPU (port B) and PPU (port A) byte ports
 * edge detect, B-over-A arbitration, request latch, read byte capture
 */
`timescale 1ns/1ps
`include "sdram_nes_macros.svh"

module nes_channel (
    input  logic                  clk,
    input  logic                  resetn,
    input  logic                  slot_ras,
    input  logic                  slot_rd,
    input  logic [`NES_AW-1:0]    addr_a,
    input  logic                  we_a,
    input  logic [7:0]            din_a,
    input  logic                  oe_a,
    input  logic [`NES_AW-1:0]    addr_b,
    input  logic                  we_b,
    input  logic [7:0]            din_b,
    input  logic                  oe_b,
    input  logic [`DATA_W-1:0]    dq_in,
    output logic                  pending,
    output logic                  bank,      // bank 0 or 1
    output logic [`CH_ROW_W-1:0]  row,
    output logic                  active,
    output logic                  write,
    output logic [`COL_W-1:0]     col,
    output logic [1:0]            ds,
    output logic [`DATA_W-1:0]    wdata,
    output logic [7:0]            dout_a,
    output logic [7:0]            dout_b
);
    logic                    oe_a_d, we_a_d, oe_b_d, we_b_d;
    logic                    req_a, req_b;
    sdram_nes_pkg::nes_src_e src;
    sdram_nes_pkg::nes_src_e src_q;
    logic [`NES_AW-1:0]      next_addr;
    logic [7:0]              next_din;
    logic                    next_we;
    logic                    byte_hi;   // odd address, upper byte
    logic [7:0]              rd_byte;

    // delayed copies only move at slot_ras, so an unserved edge persists
    assign req_a = (oe_a & ~oe_a_d) | (we_a & ~we_a_d);
    assign req_b = (oe_b & ~oe_b_d) | (we_b & ~we_b_d);

    always_comb begin
        src       = sdram_nes_pkg::NONE;
        next_addr = addr_a;
        next_din  = din_a;
        next_we   = we_a;
        if (req_b) begin            // cpu first
            src       = sdram_nes_pkg::CPU_B;
            next_addr = addr_b;
            next_din  = din_b;
            next_we   = we_b;
        end else if (req_a) begin
            src = sdram_nes_pkg::PPU_A;
        end
    end

    assign pending = req_a | req_b;
    assign bank    = next_addr[`NES_AW-1];
    assign row     = next_addr[`CH_ROW_W+`COL_W:`COL_W+1];

    always_ff @(posedge clk) begin
        if (!resetn) begin
            {oe_a_d, we_a_d, oe_b_d, we_b_d} <= '0;
            src_q  <= sdram_nes_pkg::NONE;
            active <= 1'b0;
            write  <= 1'b0;
        end else if (slot_ras) begin
            oe_a_d <= (src == sdram_nes_pkg::PPU_A) ? oe_a : (oe_a_d & oe_a);
            we_a_d <= (src == sdram_nes_pkg::PPU_A) ? we_a : (we_a_d & we_a);
            oe_b_d <= (src == sdram_nes_pkg::CPU_B) ? oe_b : (oe_b_d & oe_b);
            we_b_d <= (src == sdram_nes_pkg::CPU_B) ? we_b : (we_b_d & we_b);
            src_q  <= src;
            active <= pending;
            write  <= next_we;
        end
    end

    always_ff @(posedge clk) begin
        if (slot_ras) begin
            col     <= next_addr[`COL_W:1];
            byte_hi <= next_addr[0];
            wdata   <= {next_din, next_din};  // byte on both lanes, dqm picks
        end
    end

    assign ds      = {byte_hi, ~byte_hi};
    assign rd_byte = byte_hi ? dq_in[15:8] : dq_in[7:0];

    // byte goes to whichever port was served
    always_ff @(posedge clk) begin
        if (slot_rd && active && !write) begin
            if (src_q == sdram_nes_pkg::PPU_A)
                dout_a <= rd_byte;
            if (src_q == sdram_nes_pkg::CPU_B)
                dout_b <= rd_byte;
        end
    end

endmodule

// ==== rv_channel.sv ====
/*
 * channel 1: RISC-V 16-bit port in bank 2
 * toggle req/ack, request latch, read word capture
 */
`timescale 1ns/1ps
`include "sdram_nes_macros.svh"

module rv_channel (
    input  logic                  clk,
    input  logic                  resetn,
    input  logic                  slot_ras,
    input  logic                  slot_cas,
    input  logic                  slot_rd,
    input  logic [20:1]           rv_addr,
    input  logic [`DATA_W-1:0]    rv_din,
    input  logic [1:0]            rv_ds,
    input  logic                  rv_we,
    input  logic                  rv_req,
    input  logic [`DATA_W-1:0]    dq_in,
    output logic                  pending,
    output logic [`CH_ROW_W-1:0]  row,
    output logic                  active,
    output logic                  write,
    output logic [`COL_W-1:0]     col,
    output logic [1:0]            ds,
    output logic [`DATA_W-1:0]    wdata,
    output logic                  rv_req_ack,
    output logic [`DATA_W-1:0]    rv_dout
);
    assign pending = rv_req ^ rv_req_ack;  // open request
    assign row     = rv_addr[20:10];

    always_ff @(posedge clk) begin
        if (!resetn) begin
            active     <= 1'b0;
            write      <= 1'b0;
            rv_req_ack <= 1'b0;
        end else begin
            if (slot_ras) begin
                active <= pending;
                write  <= rv_we;
            end
            if (slot_cas && active)
                rv_req_ack <= rv_req;   // ack with the column command
        end
    end

    always_ff @(posedge clk) begin
        if (slot_ras) begin
            col   <= rv_addr[`COL_W:1];
            ds    <= rv_ds;
            wdata <= rv_din;
        end
    end

    // word lands in the next ring, latch still holds the request
    always_ff @(posedge clk) begin
        if (slot_rd && active && !write)
            rv_dout <= dq_in;
    end

endmodule

// ==== sdram_bus_driver.sv ====
/*
 * SDRAM pin register stage: command, address, bank, dqm and dq drive
 * one cycle after the sequencer decision
 */
`timescale 1ns/1ps
`include "sdram_nes_macros.svh"

module sdram_bus_driver (
    input  logic                      clk,
    input  logic                      resetn,
    input  sdram_nes_pkg::sdram_cmd_e cmd,
    input  logic                      cmd_chan,
    input  logic                      init_a10,
    input  logic                      mode_load,
    input  logic                      bank0,
    input  logic [`CH_ROW_W-1:0]      row0,
    input  logic [`COL_W-1:0]         col0,
    input  logic [1:0]                ds0,
    input  logic [`DATA_W-1:0]        wdata0,
    input  logic                      write0,
    input  logic [`CH_ROW_W-1:0]      row1,
    input  logic [`COL_W-1:0]         col1,
    input  logic [1:0]                ds1,
    input  logic [`DATA_W-1:0]        wdata1,
    inout  wire  [`DATA_W-1:0]        sdram_dq,
    output logic [`ROW_W-1:0]         sdram_a,
    output logic [`BANK_W-1:0]        sdram_ba,
    output logic [1:0]                sdram_dqm,
    output logic                      sdram_ncs,
    output logic                      sdram_nras,
    output logic                      sdram_ncas,
    output logic                      sdram_nwe,
    output logic [`DATA_W-1:0]        dq_in
);
    // cas 2, sequential, burst length 1, write burst follows
    localparam logic [`ROW_W-1:0] MODE_WORD = {6'b0, 3'(`CAS_LAT), 1'b0, 3'b000};
    localparam logic [`BANK_W-1:0] RV_BANK  = 2'd2;

    sdram_nes_pkg::sdram_cmd_e cmd_q;
    logic                      dq_oe;
    logic [`DATA_W-1:0]        dq_out;
    logic                      act_bank0;  // bank opened by the last chan 0 activate
    logic                      col_cmd;
    logic                      wr_sel;

    assign {sdram_ncs, sdram_nras, sdram_ncas, sdram_nwe} = cmd_q;
    assign sdram_dq = dq_oe ? dq_out : {`DATA_W{1'bz}};
    assign dq_in    = sdram_dq;

    assign col_cmd = (cmd == sdram_nes_pkg::READ) || (cmd == sdram_nes_pkg::WRITE);
    assign wr_sel  = cmd_chan ? (cmd == sdram_nes_pkg::WRITE) : write0;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            cmd_q     <= sdram_nes_pkg::NOP;
            dq_oe     <= 1'b0;
            sdram_dqm <= 2'b11;
        end else begin
            cmd_q     <= cmd;
            dq_oe     <= 1'b0;
            sdram_dqm <= 2'b11;
            if (col_cmd) begin
                dq_oe     <= wr_sel;
                sdram_dqm <= wr_sel ? ~(cmd_chan ? ds1 : ds0) : 2'b00;  // read: both lanes
            end
        end
    end

    always_ff @(posedge clk) begin
        sdram_a  <= '0;
        sdram_ba <= '0;     // precharge-all and mode set use bank 0
        if (cmd == sdram_nes_pkg::ACTIVATE) begin
            sdram_a  <= cmd_chan ? {2'b00, row1} : {2'b00, row0};
            sdram_ba <= cmd_chan ? RV_BANK : {1'b0, bank0};
            if (!cmd_chan)
                act_bank0 <= bank0;
        end else if (col_cmd) begin
            sdram_a  <= {3'b001, 1'b0, cmd_chan ? col1 : col0};  // a10 auto precharge
            sdram_ba <= cmd_chan ? RV_BANK : {1'b0, act_bank0};
            if (wr_sel)
                dq_out <= cmd_chan ? wdata1 : wdata0;
        end else if (mode_load) begin
            sdram_a <= MODE_WORD;
        end else if (init_a10) begin
            sdram_a[10] <= 1'b1;
        end
    end

endmodule

// ==== sdram_model.sv ====
/*
 * behavioural CL2 SDRAM for the testbench
 * one-word bursts, auto-precharge, byte mask, address-derived fill
 */
`timescale 1ns/1ps
`include "sdram_nes_macros.svh"

module sdram_model (
    input  logic                  clk,
    inout  wire  [`DATA_W-1:0]    dq,
    input  logic [`ROW_W-1:0]     a,
    input  logic [`BANK_W-1:0]    ba,
    input  logic [1:0]            dqm,
    input  logic                  ncs,
    input  logic                  nras,
    input  logic                  ncas,
    input  logic                  nwe
);
    logic [`DATA_W-1:0] mem [int];           // sparse, key = {bank, row, col}
    logic [`ROW_W-1:0]  open_row [4];
    logic [3:0]         pcmd;
    logic               rd_pend, out_en;     // two-stage CL2 pipe
    logic [`DATA_W-1:0] rd_word, out_data;
    int                 key;

    assign pcmd = {ncs, nras, ncas, nwe};
    assign dq   = out_en ? out_data : {`DATA_W{1'bz}};

    // untouched words read back a pattern built from every address bit
    function automatic logic [`DATA_W-1:0] word_at(input int k);
        if (mem.exists(k))
            return mem[k];
        return 16'(k) ^ 16'(k >> 8) ^ 16'h5a3c;
    endfunction

    always @(posedge clk) begin
        key = {ba, open_row[ba], a[`COL_W-1:0]};
        rd_pend  <= (pcmd == sdram_nes_pkg::READ);
        out_en   <= rd_pend;
        out_data <= rd_word;
        case (pcmd)
            sdram_nes_pkg::ACTIVATE: open_row[ba] <= a;
            sdram_nes_pkg::READ:     rd_word <= word_at(key);
            sdram_nes_pkg::WRITE: begin
                mem[key] = word_at(key);
                if (!dqm[0]) mem[key][7:0]  = dq[7:0];
                if (!dqm[1]) mem[key][15:8] = dq[15:8];
            end
            default: ;                       // row closes itself, a10 always set
        endcase
    end

endmodule

// ==== sdram_nes.sv ====
/*
 * two-channel CL2 SDRAM controller top
 * channel 0 = NES CPU/PPU byte ports (banks 0/1), channel 1 = RISC-V (bank 2)
 */
`timescale 1ns/1ps
`include "sdram_nes_macros.svh"

module sdram_nes (
    input  logic                  clk,
    input  logic                  resetn,
    input  logic                  clkref,
    inout  wire  [`DATA_W-1:0]    sdram_dq,
    output logic [`ROW_W-1:0]     sdram_a,
    output logic [`BANK_W-1:0]    sdram_ba,
    output logic [1:0]            sdram_dqm,
    output logic                  sdram_ncs,
    output logic                  sdram_nras,
    output logic                  sdram_ncas,
    output logic                  sdram_nwe,
    output logic                  sdram_cke,
    output logic                  busy,
    input  logic [`NES_AW-1:0]    addr_a,   // PPU
    input  logic                  we_a,
    input  logic [7:0]            din_a,
    input  logic                  oe_a,
    output logic [7:0]            dout_a,
    input  logic [`NES_AW-1:0]    addr_b,   // CPU
    input  logic                  we_b,
    input  logic [7:0]            din_b,
    input  logic                  oe_b,
    output logic [7:0]            dout_b,
    input  logic [20:1]           rv_addr,
    input  logic [`DATA_W-1:0]    rv_din,
    input  logic [1:0]            rv_ds,
    input  logic                  rv_we,
    input  logic                  rv_req,
    output logic [`DATA_W-1:0]    rv_dout,
    output logic                  rv_req_ack
);
    logic [`SLOT_COUNT-1:0]   slot;
    sdram_nes_pkg::sdram_cmd_e cmd;
    logic                     cmd_chan;
    logic                     init_a10;
    logic                     mode_load;
    logic [`DATA_W-1:0]       dq_in;
    // channel 0 fields
    logic                     pending0, active0, write0, bank0;
    logic [`CH_ROW_W-1:0]     row0;
    logic [`COL_W-1:0]        col0;
    logic [1:0]               ds0;
    logic [`DATA_W-1:0]       wdata0;
    // channel 1 fields
    logic                     pending1, active1, write1;
    logic [`CH_ROW_W-1:0]     row1;
    logic [`COL_W-1:0]        col1;
    logic [1:0]               ds1;
    logic [`DATA_W-1:0]       wdata1;

    assign sdram_cke = 1'b1;

    sdram_sequencer i_seq (
        .clk, .resetn, .clkref,
        .pending0, .active0, .write0, .pending1, .active1, .write1,
        .slot, .cmd, .cmd_chan, .init_a10, .mode_load, .busy
    );

    nes_channel i_nes (
        .clk, .resetn,
        .slot_ras (slot[`SLOT_RAS0]),
        .slot_rd  (slot[`SLOT_RD0]),
        .addr_a, .we_a, .din_a, .oe_a, .addr_b, .we_b, .din_b, .oe_b, .dq_in,
        .pending (pending0), .bank (bank0), .row (row0), .active (active0),
        .write (write0), .col (col0), .ds (ds0), .wdata (wdata0),
        .dout_a, .dout_b
    );

    rv_channel i_rv (
        .clk, .resetn,
        .slot_ras (slot[`SLOT_RAS1]),
        .slot_cas (slot[`SLOT_CAS1]),
        .slot_rd  (slot[`SLOT_RD1]),
        .rv_addr, .rv_din, .rv_ds, .rv_we, .rv_req, .dq_in,
        .pending (pending1), .row (row1), .active (active1), .write (write1),
        .col (col1), .ds (ds1), .wdata (wdata1), .rv_req_ack, .rv_dout
    );

    sdram_bus_driver i_drv (
        .clk, .resetn, .cmd, .cmd_chan, .init_a10, .mode_load,
        .bank0, .row0, .col0, .ds0, .wdata0, .write0,
        .row1, .col1, .ds1, .wdata1,
        .sdram_dq, .sdram_a, .sdram_ba, .sdram_dqm,
        .sdram_ncs, .sdram_nras, .sdram_ncas, .sdram_nwe, .dq_in
    );

endmodule

// ==== sdram_nes_macros.svh ====
/*
 * clock, SDRAM timing, field width, refresh and slot macros
 * for the two-channel NES / RISC-V SDRAM controller
 */
`ifndef SDRAM_NES_MACROS_SVH
`define SDRAM_NES_MACROS_SVH

`define SDRAM_FREQ      64_800_000                              // Hz
`define POWERON_CYCLES  (`SDRAM_FREQ / 1000 * 200 / 1000)       // 200 us, ~12960 cycles
`define T_RP            2   // precharge to activate/refresh
`define T_RC            6   // refresh to refresh
`define T_MRD           2   // mode set to first command
`define CAS_LAT         2
`define REFRESH_CYCLES  501 // 64 ms / 8192 rows at 64.8 MHz

`define DATA_W          16
`define ROW_W           13  // pin address bus
`define BANK_W          2
`define NES_AW          22
`define CH_ROW_W        11  // row bits a channel supplies
`define COL_W           9

`define SLOT_RAS0       0
`define SLOT_CAS0       1
`define SLOT_RAS1       2
`define SLOT_CAS1       4
`define SLOT_RD1        1   // rv read word on dq
`define SLOT_RD0        4   // nes read byte on dq
`define SLOT_COUNT      6

`endif

// ==== sdram_nes_pkg.sv ====
/*
 * shared types: SDRAM command opcodes, controller states
 * and the channel 0 request source
 */
package sdram_nes_pkg;

    // opcode bits are {cs_n, ras_n, cas_n, we_n}
    typedef enum logic [3:0] {
        NOP       = 4'b1111,
        MODE_SET  = 4'b0000,
        ACTIVATE  = 4'b0011,
        WRITE     = 4'b0100,
        READ      = 4'b0101,
        REFRESH   = 4'b0001,
        PRECHARGE = 4'b0010
    } sdram_cmd_e;

    typedef enum logic [1:0] {
        POWERON_WAIT,
        INIT,
        NORMAL
    } ctrl_state_e;

    typedef enum logic [1:0] {
        NONE,
        PPU_A,
        CPU_B
    } nes_src_e;

endpackage

// ==== sdram_nes_sva.sv ====
/*
 * bound protocol checks on the controller pins
 * init order, busy timing, cpu priority, column after activate, idle refresh spacing
 */
`timescale 1ns/1ps
`include "sdram_nes_macros.svh"

module sdram_nes_sva (
    input logic                        clk,
    input logic                        resetn,
    input logic                        busy,
    input logic                        sdram_ncs,
    input logic                        sdram_nras,
    input logic                        sdram_ncas,
    input logic                        sdram_nwe,
    input logic [`ROW_W-1:0]           sdram_a,
    input logic [`BANK_W-1:0]          sdram_ba,
    input sdram_nes_pkg::ctrl_state_e  state,
    input logic                        slot_ras0,
    input logic                        req_a,
    input logic                        req_b,
    input logic [`NES_AW-1:0]          addr_b
);
    logic [3:0] pcmd;
    logic [2:0] init_idx;    // init commands seen so far
    int         ready_cnt;   // cycles since reset release
    int         since_ref;   // idle cycles since refresh or activate
    int         fail_cnt = 0;

    assign pcmd = {sdram_ncs, sdram_nras, sdram_ncas, sdram_nwe};

    function automatic logic [3:0] init_cmd(input logic [2:0] idx);
        case (idx)
            3'd0:    return sdram_nes_pkg::PRECHARGE;
            3'd1:    return sdram_nes_pkg::REFRESH;
            3'd2:    return sdram_nes_pkg::REFRESH;
            default: return sdram_nes_pkg::MODE_SET;
        endcase
    endfunction

    always_ff @(posedge clk) begin
        if (!resetn) begin
            init_idx  <= '0;
            ready_cnt <= 0;
            since_ref <= 0;
        end else begin
            ready_cnt <= ready_cnt + 1;
            if (busy && pcmd != sdram_nes_pkg::NOP)
                init_idx <= init_idx + 1'b1;
            if (busy || pcmd == sdram_nes_pkg::REFRESH || pcmd == sdram_nes_pkg::ACTIVATE)
                since_ref <= 0;
            else
                since_ref <= since_ref + 1;
        end
    end

    a_init_order: assert property (@(posedge clk) disable iff (!resetn)
        (busy && pcmd != sdram_nes_pkg::NOP) |-> (init_idx < 4 && pcmd == init_cmd(init_idx)))
        else begin $error("init command out of order"); fail_cnt++; end

    a_busy_fall: assert property (@(posedge clk) disable iff (!resetn)
        $fell(busy) |-> (init_idx == 4 && ready_cnt == `POWERON_CYCLES + 17))
        else begin $error("busy fell at the wrong time"); fail_cnt++; end

    // pins stay quiet for the whole 200 us wait
    a_wait_quiet: assert property (@(posedge clk) disable iff (!resetn)
        (state == sdram_nes_pkg::POWERON_WAIT) |-> pcmd == sdram_nes_pkg::NOP)
        else begin $error("command issued during the power-on wait"); fail_cnt++; end

    // both ports rise together, the activate on the pins carries b's bank and row
    a_cpu_first: assert property (@(posedge clk) disable iff (!resetn)
        (slot_ras0 && req_a && req_b) |=>
        (pcmd == sdram_nes_pkg::ACTIVATE &&
         sdram_ba == {1'b0, $past(addr_b[`NES_AW-1])} &&
         sdram_a == {2'b00, $past(addr_b[`CH_ROW_W+`COL_W:`COL_W+1])}))
        else begin $error("cpu port lost arbitration"); fail_cnt++; end

    // chan 0 uses one cycle from activate, rv uses two
    a_col_after_act: assert property (@(posedge clk) disable iff (!resetn)
        (pcmd == sdram_nes_pkg::READ || pcmd == sdram_nes_pkg::WRITE) |->
        (($past(pcmd) == sdram_nes_pkg::ACTIVATE && $past(sdram_ba) == sdram_ba) ||
         ($past(pcmd, 2) == sdram_nes_pkg::ACTIVATE && $past(sdram_ba, 2) == sdram_ba)))
        else begin $error("column command without activate"); fail_cnt++; end

    a_refresh_gap: assert property (@(posedge clk) disable iff (!resetn)
        since_ref <= `REFRESH_CYCLES + 12)
        else begin $error("refresh overdue"); fail_cnt++; end

endmodule

// ==== sdram_sequencer.sv ====
/*
 * power-on wait, init sequence, clkref-phased six-slot ring,
 * refresh timer and per-cycle command choice
 */
`timescale 1ns/1ps
`include "sdram_nes_macros.svh"

module sdram_sequencer (
    input  logic                      clk,
    input  logic                      resetn,
    input  logic                      clkref,
    input  logic                      pending0,
    input  logic                      active0,
    input  logic                      write0,
    input  logic                      pending1,
    input  logic                      active1,
    input  logic                      write1,
    output logic [`SLOT_COUNT-1:0]    slot,      // one-hot ring position
    output sdram_nes_pkg::sdram_cmd_e cmd,
    output logic                      cmd_chan,  // 1 selects rv fields
    output logic                      init_a10,  // precharge all
    output logic                      mode_load,
    output logic                      busy
);
    localparam int PON_W     = $clog2(`POWERON_CYCLES + 1);
    localparam int REF1_STEP = `T_RP;
    localparam int REF2_STEP = `T_RP + `T_RC;
    localparam int MRS_STEP  = `T_RP + 2 * `T_RC;
    localparam int DONE_STEP = MRS_STEP + `T_MRD;   // 16
    localparam int RCNT_W    = $clog2(`REFRESH_CYCLES + 1);

    sdram_nes_pkg::ctrl_state_e state;
    logic [PON_W-1:0]           pon_cnt;
    logic [DONE_STEP:0]         init_step;  // one-hot init cycle
    logic                       clkref_r;
    logic [RCNT_W-1:0]          refresh_cnt;
    logic                       refresh_due;
    logic                       refresh_go;

    assign busy        = (state != sdram_nes_pkg::NORMAL);
    assign refresh_due = (refresh_cnt == RCNT_W'(`REFRESH_CYCLES));  // saturates there
    assign init_a10    = init_step[0];
    assign mode_load   = init_step[MRS_STEP];

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state       <= sdram_nes_pkg::POWERON_WAIT;
            pon_cnt     <= '0;
            init_step   <= '0;
            slot        <= '0;
            clkref_r    <= 1'b0;
            refresh_cnt <= '0;
        end else begin
            clkref_r <= clkref;
            case (state)
                sdram_nes_pkg::POWERON_WAIT: begin
                    pon_cnt <= pon_cnt + 1'b1;
                    if (pon_cnt == PON_W'(`POWERON_CYCLES - 1)) begin
                        state     <= sdram_nes_pkg::INIT;
                        init_step <= 1;
                    end
                end
                sdram_nes_pkg::INIT: begin
                    init_step <= init_step << 1;
                    if (init_step[DONE_STEP]) begin
                        state <= sdram_nes_pkg::NORMAL;
                        slot  <= 1;             // ring starts at RAS0
                    end
                end
                default: begin
                    if (clkref && !clkref_r)    // re-phase, slot 0 follows
                        slot <= {1'b1, {(`SLOT_COUNT-1){1'b0}}};
                    else
                        slot <= {slot[`SLOT_COUNT-2:0], slot[`SLOT_COUNT-1]};
                    if (refresh_go)
                        refresh_cnt <= '0;
                    else if (!refresh_due)
                        refresh_cnt <= refresh_cnt + 1'b1;
                end
            endcase
        end
    end

    // one command per cycle
    always_comb begin
        cmd        = sdram_nes_pkg::NOP;
        cmd_chan   = 1'b0;
        refresh_go = 1'b0;
        if (state == sdram_nes_pkg::INIT) begin
            if (init_step[0])
                cmd = sdram_nes_pkg::PRECHARGE;
            if (init_step[REF1_STEP] || init_step[REF2_STEP])
                cmd = sdram_nes_pkg::REFRESH;
            if (init_step[MRS_STEP])
                cmd = sdram_nes_pkg::MODE_SET;
        end else if (state == sdram_nes_pkg::NORMAL) begin
            cmd_chan = slot[`SLOT_RAS1] | slot[`SLOT_CAS1];
            if (slot[`SLOT_RAS0] && pending0)
                cmd = sdram_nes_pkg::ACTIVATE;
            if (slot[`SLOT_CAS0] && active0) begin
                if (write0)
                    cmd = sdram_nes_pkg::WRITE;
                else
                    cmd = sdram_nes_pkg::READ;
            end
            if (slot[`SLOT_RAS1]) begin
                if (pending1) begin
                    cmd = sdram_nes_pkg::ACTIVATE;
                end else if (!active0 && !active1 && refresh_due) begin
                    cmd        = sdram_nes_pkg::REFRESH;  // all banks idle here
                    refresh_go = 1'b1;
                end
            end
            if (slot[`SLOT_CAS1] && active1) begin
                if (write1)
                    cmd = sdram_nes_pkg::WRITE;
                else
                    cmd = sdram_nes_pkg::READ;
            end
        end
    end

endmodule

// ==== tb_sdram_nes.sv ====
/*
 * testbench for the two-channel SDRAM controller
 * init, cpu port, ppu port and priority, rv port, idle refresh
 */
`timescale 1ns/1ps
`include "sdram_nes_macros.svh"

module tb_sdram_nes;
    localparam int CYC         = 100;
    localparam int N_TESTS     = 5;
    localparam int IDLE_CYCLES = 1100;

    logic clk, resetn, clkref, busy;
    wire  [`DATA_W-1:0] sdram_dq;
    logic [`ROW_W-1:0]  sdram_a;
    logic [`BANK_W-1:0] sdram_ba;
    logic [1:0]         sdram_dqm;
    logic sdram_ncs, sdram_nras, sdram_ncas, sdram_nwe, sdram_cke;
    logic [`NES_AW-1:0] addr_a, addr_b;
    logic we_a, oe_a, we_b, oe_b;
    logic [7:0]         din_a, din_b, dout_a, dout_b;
    logic [20:1]        rv_addr;
    logic [`DATA_W-1:0] rv_din, rv_dout;
    logic [1:0]         rv_ds;
    logic rv_we, rv_req, rv_req_ack;

    logic [7:0] shadow [int];   // expected bytes, nes by address, rv offset by 1<<24
    logic [`NES_AW-1:0] nes_list [$];
    logic [20:1]        rv_list [$];
    int cyc = 0;
    int checks = 0, errors = 0, n_tests = 0;
    int base_checks = 0, base_errors = 0, base_sva = 0;

    sdram_nes i_dut (.*);

    sdram_model i_mem (
        .clk, .dq (sdram_dq), .a (sdram_a), .ba (sdram_ba), .dqm (sdram_dqm),
        .ncs (sdram_ncs), .nras (sdram_nras), .ncas (sdram_ncas), .nwe (sdram_nwe)
    );

    bind sdram_nes sdram_nes_sva i_sva (
        .clk, .resetn, .busy, .sdram_ncs, .sdram_nras, .sdram_ncas, .sdram_nwe,
        .sdram_a, .sdram_ba,
        .state (i_seq.state), .slot_ras0 (i_seq.slot[0]), .req_a (i_nes.req_a),
        .req_b (i_nes.req_b), .addr_b
    );

    initial begin
        clk = 1'b0;
        forever #(CYC / 2) clk = ~clk;
    end

    // clkref high two cycles out of six
    always @(posedge clk) begin
        cyc <= cyc + 1;
        #10 clkref <= (cyc % 6) < 2;
    end

    initial begin
        #(CYC * (`POWERON_CYCLES + 400 * N_TESTS + IDLE_CYCLES));
        $display("timeout: the run did not finish in the allowed time");
        $display("CHECKS FAILED");
        $finish;
    end

    task automatic check(input bit ok, input string msg);
        checks++;
        assert (ok) else begin
            $display("FAILED @%0t ns: %s", $time, msg);
            errors++;
        end
    endtask

    task automatic report(input string name);
        int sva_now;
        sva_now = i_dut.i_sva.fail_cnt;
        $display("test %-10s %0d checks, %0d failures, %0d assertion failures", name,
                 checks - base_checks, errors - base_errors, sva_now - base_sva);
        base_checks = checks;
        base_errors = errors;
        base_sva    = sva_now;
        n_tests++;
    endtask

    // edge where clkref is about to rise, then step past it
    task automatic ring_start();
        do @(posedge clk); while (cyc % 6 != 5);
        #10;
    endtask

    task automatic idle_ring();
        repeat (`SLOT_COUNT) @(posedge clk);
    endtask

    task automatic nes_access(input bit port_b, input bit wr, input logic [21:0] addr,
                              input logic [7:0] data);
        ring_start();
        if (port_b) begin
            addr_b = addr; din_b = data; we_b = wr; oe_b = !wr;
        end else begin
            addr_a = addr; din_a = data; we_a = wr; oe_a = !wr;
        end
        if (wr)
            shadow[addr] = data;
        repeat (7) @(posedge clk);          // byte lands at slot 4 of this ring
        #10;
        if (!wr && port_b)
            check(dout_b == shadow[addr], $sformatf("dout_b %h, expected %h at %h",
                  dout_b, shadow[addr], addr));
        if (!wr && !port_b)
            check(dout_a == shadow[addr], $sformatf("dout_a %h, expected %h at %h",
                  dout_a, shadow[addr], addr));
        {we_a, oe_a, we_b, oe_b} = '0;
        idle_ring();
    endtask

    // both ports rise together, b in this ring and a in the next
    task automatic nes_pair(input bit wr, input logic [21:0] adr_a, input logic [21:0] adr_b,
                            input logic [7:0] da, input logic [7:0] db);
        ring_start();
        addr_a = adr_a; din_a = da; we_a = wr; oe_a = !wr;
        addr_b = adr_b; din_b = db; we_b = wr; oe_b = !wr;
        if (wr) begin
            shadow[adr_b] = db;
            shadow[adr_a] = da;
        end
        repeat (7) @(posedge clk);
        #10;
        if (!wr)
            check(dout_b == shadow[adr_b], $sformatf("pair dout_b %h, expected %h",
                  dout_b, shadow[adr_b]));
        repeat (6) @(posedge clk);
        #10;
        if (!wr)
            check(dout_a == shadow[adr_a], $sformatf("pair dout_a %h, expected %h",
                  dout_a, shadow[adr_a]));
        {we_a, oe_a, we_b, oe_b} = '0;
        idle_ring();
    endtask

    task automatic rv_access(input bit wr, input logic [20:1] adr, input logic [15:0] data,
                             input logic [1:0] ds);
        int n;
        int key;
        logic [15:0] exp;
        key = (1 << 24) | (int'(adr) << 1);
        @(posedge clk);
        #10;
        rv_addr = adr; rv_din = data; rv_ds = ds; rv_we = wr;
        rv_req = ~rv_req;
        n = 0;
        while (rv_req_ack != rv_req && n < 12) begin
            @(posedge clk);
            #10;
            n++;
        end
        check(rv_req_ack == rv_req, "rv_req_ack did not follow rv_req within 12 cycles");
        if (wr) begin
            if (ds[0]) shadow[key]     = data[7:0];
            if (ds[1]) shadow[key + 1] = data[15:8];
        end else begin
            exp = {shadow[key + 1], shadow[key]};
            repeat (3) @(posedge clk);
            #10;
            check(rv_dout == exp, $sformatf("rv_dout %h, expected %h at %h", rv_dout, exp, adr));
        end
        idle_ring();
    endtask

    initial begin
        logic [21:0] adr, adr2;
        logic [20:1] radr;
        void'($urandom(50));
        resetn = 1'b0; clkref = 1'b0;
        addr_a = '0; we_a = 1'b0; din_a = '0; oe_a = 1'b0;
        addr_b = '0; we_b = 1'b0; din_b = '0; oe_b = 1'b0;
        rv_addr = '0; rv_din = '0; rv_ds = '0; rv_we = 1'b0; rv_req = 1'b0;
        repeat (3) @(posedge clk);
        #10 resetn = 1'b1;

        // pins idle and bus released while the power-on wait runs
        @(posedge clk);
        #10;
        check(busy && rv_req_ack == 1'b0 && sdram_cke == 1'b1 && sdram_dqm == 2'b11 &&
              sdram_dq === {`DATA_W{1'bz}} &&
              {sdram_ncs, sdram_nras, sdram_ncas, sdram_nwe} == 4'b1111,
              "controller not idle after reset");

        while (busy) @(posedge clk);
        #10;
        report("init");

        for (int i = 0; i < 8; i++) begin   // both banks, both byte lanes
            adr = $urandom;
            adr[21] = i[0];
            adr[0]  = i[1];
            nes_list.push_back(adr);
            nes_access(1'b1, 1'b1, adr, 8'($urandom));
        end
        foreach (nes_list[i])
            nes_access(1'b1, 1'b0, nes_list[i], 8'h00);
        report("cpu_port");

        for (int i = 0; i < 4; i++) begin
            adr = $urandom;
            adr[0] = i[0];
            nes_access(1'b0, 1'b1, adr, 8'($urandom));
            nes_access(1'b0, 1'b0, adr, 8'h00);
        end
        adr  = $urandom;
        adr2 = adr ^ 22'h200401;            // other bank, other lane
        nes_pair(1'b1, adr, adr2, 8'($urandom), 8'($urandom));
        nes_pair(1'b0, adr, adr2, 8'h00, 8'h00);
        report("ppu_prio");

        for (int i = 0; i < 5; i++) begin
            radr = $urandom;
            rv_list.push_back(radr);
            rv_access(1'b1, radr, 16'($urandom), 2'b11);
            rv_access(1'b1, radr, 16'($urandom), 2'($urandom));
            rv_access(1'b0, radr, 16'h0000, 2'b11);
        end
        report("rv_port");

        repeat (IDLE_CYCLES) @(posedge clk);
        nes_access(1'b1, 1'b0, nes_list[0], 8'h00);   // contents survive refresh
        rv_access(1'b0, rv_list[0], 16'h0000, 2'b11);
        report("refresh");

        $display("%0d tests, %0d checks, %0d failures, %0d assertion failures",
                 n_tests, checks, errors, i_dut.i_sva.fail_cnt);
        if (errors == 0 && i_dut.i_sva.fail_cnt == 0)
            $display("ALL CHECKS PASSED");
        else
            $display("CHECKS FAILED");
        $finish;
    end

endmodule
